/* rtl/qdr_bus_pkg.sv */
`default_nettype none

package qdr_bus_pkg;

  localparam int BUS_DW    = 16;
  localparam int ADR_W     = 8;
  localparam int REG_IDX_W = 7;

  // word index, decoded from adr[7:1]
  localparam logic [REG_IDX_W-1:0] REG_CTRL    = 7'd0;
  localparam logic [REG_IDX_W-1:0] REG_STATUS  = 7'd1;
  localparam logic [REG_IDX_W-1:0] REG_ADDR_LO = 7'd2;
  localparam logic [REG_IDX_W-1:0] REG_ADDR_HI = 7'd3;
  localparam logic [REG_IDX_W-1:0] REG_MASK    = 7'd4;
  localparam logic [REG_IDX_W-1:0] REG_WDATA0  = 7'd5;
  localparam logic [REG_IDX_W-1:0] REG_WDATA4  = 7'd9;
  localparam logic [REG_IDX_W-1:0] REG_RDATA0  = 7'd10;
  localparam logic [REG_IDX_W-1:0] REG_RDATA4  = 7'd14;

  // 16-bit words needed to cover one 72-bit burst
  localparam int DATA_WORDS = 5;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [1:0]        sel;
    logic [ADR_W-1:0]  adr;
    logic [BUS_DW-1:0] dat;
  } bus_req_t;

endpackage

`default_nettype wire

/* rtl/qdr_mem_pkg.sv */
`default_nettype none

package qdr_mem_pkg;

  localparam int ADDR_BITS = 22;
  localparam int LANE_BITS = 18;
  localparam int LANES     = 4;
  localparam int BEATS     = 2;
  localparam int BEAT_BITS = LANES * LANE_BITS / BEATS;
  // one mask bit per 9-bit byte
  localparam int MASK_BITS = 8;
  localparam int BEAT_MASK = MASK_BITS / BEATS;

  localparam int RST_STRETCH = 8;
  localparam int RST_CNT_W   = $clog2(RST_STRETCH + 1);
  localparam logic [RST_CNT_W-1:0] RST_LOAD = RST_CNT_W'(RST_STRETCH);

  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam logic [FIFO_AW:0] FIFO_FULL = (FIFO_AW + 1)'(FIFO_DEPTH);

  // lanes on the register side, beats on the QDR side
  typedef union packed {
    logic [LANES-1:0][LANE_BITS-1:0] lane;
    logic [BEATS-1:0][BEAT_BITS-1:0] beat;
  } burst_u;

  typedef struct packed {
    logic                 is_read;
    logic [ADDR_BITS-1:0] addr;
    logic [MASK_BITS-1:0] mask;
    burst_u               data;
  } qdr_cmd_t;

  typedef struct packed {
    logic   valid;
    burst_u data;
  } rd_result_t;

endpackage

`default_nettype wire

/* rtl/qdr_cmd_regs.sv */
`default_nettype none
`timescale 1ns/1ps

module qdr_cmd_regs (
  input  wire                                  qdr_clk_i,
  input  wire                                  wb_rst_i,
  input  wire qdr_bus_pkg::bus_req_t           bus_i,
  input  wire                                  full_i,
  input  wire qdr_mem_pkg::rd_result_t         rd_res_i,
  input  wire                                  seq_idle_i,
  output logic [qdr_bus_pkg::BUS_DW-1:0]       dat_o,
  output logic                                 ack_o,
  output logic                                 push_o,
  output qdr_mem_pkg::qdr_cmd_t                cmd_o
);

  logic [qdr_bus_pkg::REG_IDX_W-1:0]    adr_idx;
  logic [2:0]                           wd_idx;
  logic [2:0]                           rd_idx;
  logic                                 access;
  logic                                 ctrl_wr;
  logic                                 want_push;
  logic                                 stall;
  logic                                 do_push;
  logic                                 busy;
  logic                                 rd_done;
  logic                                 push_rd_q;
  logic [qdr_bus_pkg::BUS_DW-1:0]       bmask;
  logic [qdr_bus_pkg::BUS_DW-1:0]       rd_word;
  logic [qdr_bus_pkg::BUS_DW-1:0]       wr_word;
  logic [qdr_mem_pkg::ADDR_BITS-1:0]    addr_q;
  logic [qdr_mem_pkg::MASK_BITS-1:0]    mask_q;
  qdr_mem_pkg::burst_u                  wr_burst;
  qdr_mem_pkg::burst_u                  wr_burst_nxt;
  qdr_mem_pkg::burst_u                  rd_buf;

  // 16-bit view of a burst, top word zero padded
  function automatic logic [qdr_bus_pkg::BUS_DW-1:0] burst_word(
    input qdr_mem_pkg::burst_u b,
    input logic [2:0]          k
  );
    logic [qdr_bus_pkg::DATA_WORDS*qdr_bus_pkg::BUS_DW-1:0] wide;
    wide = (qdr_bus_pkg::DATA_WORDS * qdr_bus_pkg::BUS_DW)'(b);
    return wide[int'(k)*qdr_bus_pkg::BUS_DW +: qdr_bus_pkg::BUS_DW];
  endfunction

  assign adr_idx = bus_i.adr[7:1];
  assign wd_idx  = 3'(adr_idx - qdr_bus_pkg::REG_WDATA0);
  assign rd_idx  = 3'(adr_idx - qdr_bus_pkg::REG_RDATA0);
  assign access  = bus_i.cyc && bus_i.stb && !ack_o;
  assign bmask   = {{8{bus_i.sel[1]}}, {8{bus_i.sel[0]}}};
  assign busy    = !seq_idle_i || push_o;

  always_comb begin
    rd_word = '0;
    case (adr_idx)
      qdr_bus_pkg::REG_STATUS:  rd_word = {14'b0, busy, rd_done};
      qdr_bus_pkg::REG_ADDR_LO: rd_word = addr_q[qdr_bus_pkg::BUS_DW-1:0];
      qdr_bus_pkg::REG_ADDR_HI: begin
        rd_word = qdr_bus_pkg::BUS_DW'(addr_q[qdr_mem_pkg::ADDR_BITS-1:qdr_bus_pkg::BUS_DW]);
      end
      qdr_bus_pkg::REG_MASK:    rd_word = qdr_bus_pkg::BUS_DW'(mask_q);
      default: begin
        if (adr_idx inside {[qdr_bus_pkg::REG_WDATA0:qdr_bus_pkg::REG_WDATA4]}) begin
          rd_word = burst_word(wr_burst, wd_idx);
        end else if (adr_idx inside {[qdr_bus_pkg::REG_RDATA0:qdr_bus_pkg::REG_RDATA4]}) begin
          rd_word = burst_word(rd_buf, rd_idx);
        end
      end
    endcase
  end

  // byte lanes not selected keep their old value
  assign wr_word = (rd_word & ~bmask) | (bus_i.dat & bmask);

  // scatter the 16-bit word over the 18-bit lanes
  always_comb begin
    int off;
    wr_burst_nxt = wr_burst;
    for (int l = 0; l < qdr_mem_pkg::LANES; l++) begin
      for (int b = 0; b < qdr_mem_pkg::LANE_BITS; b++) begin
        off = l * qdr_mem_pkg::LANE_BITS + b - int'(wd_idx) * qdr_bus_pkg::BUS_DW;
        if (off >= 0 && off < qdr_bus_pkg::BUS_DW) begin
          wr_burst_nxt.lane[l][b] = wr_word[off[3:0]];
        end
      end
    end
  end

  assign ctrl_wr   = access && bus_i.we && (adr_idx == qdr_bus_pkg::REG_CTRL);
  assign want_push = ctrl_wr && (wr_word[1:0] != 2'b00);
  // hold off the ack until the queue has room
  assign stall     = want_push && full_i;
  assign do_push   = want_push && !full_i;

  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      ack_o   <= 1'b0;
      push_o  <= 1'b0;
      rd_done <= 1'b0;
    end else begin
      ack_o  <= access && !stall;
      push_o <= do_push;
      if (push_o && cmd_o.is_read) begin
        rd_done <= 1'b0;
      end else if (rd_res_i.valid) begin
        rd_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge qdr_clk_i) begin
    // bit 0 wins when both are set
    if (do_push) begin
      push_rd_q <= !wr_word[0];
    end
    if (access && !bus_i.we) begin
      dat_o <= rd_word;
    end
    if (access && bus_i.we) begin
      case (adr_idx)
        qdr_bus_pkg::REG_ADDR_LO: addr_q[qdr_bus_pkg::BUS_DW-1:0] <= wr_word;
        qdr_bus_pkg::REG_ADDR_HI: begin
          addr_q[qdr_mem_pkg::ADDR_BITS-1:qdr_bus_pkg::BUS_DW] <=
            wr_word[qdr_mem_pkg::ADDR_BITS-qdr_bus_pkg::BUS_DW-1:0];
        end
        qdr_bus_pkg::REG_MASK:    mask_q <= wr_word[qdr_mem_pkg::MASK_BITS-1:0];
        default: begin
          if (adr_idx inside {[qdr_bus_pkg::REG_WDATA0:qdr_bus_pkg::REG_WDATA4]}) begin
            wr_burst <= wr_burst_nxt;
          end
        end
      endcase
    end
    if (rd_res_i.valid) begin
      rd_buf <= rd_res_i.data;
    end
  end

  assign cmd_o.is_read = push_rd_q;
  assign cmd_o.addr    = addr_q;
  assign cmd_o.mask    = mask_q;
  assign cmd_o.data    = wr_burst;

endmodule

`default_nettype wire

/* rtl/qdr_cmd_fifo.sv */
`default_nettype none
`timescale 1ns/1ps

module qdr_cmd_fifo (
  input  wire                        qdr_clk_i,
  input  wire                        wb_rst_i,
  input  wire                        push_i,
  input  wire qdr_mem_pkg::qdr_cmd_t cmd_i,
  input  wire                        pop_i,
  output qdr_mem_pkg::qdr_cmd_t      cmd_o,
  output logic                       not_empty_o,
  output logic                       full_o,
  output logic                       empty_o
);

  qdr_mem_pkg::qdr_cmd_t             mem [qdr_mem_pkg::FIFO_DEPTH];
  logic [qdr_mem_pkg::FIFO_AW-1:0]   wr_ptr;
  logic [qdr_mem_pkg::FIFO_AW-1:0]   rd_ptr;
  logic [qdr_mem_pkg::FIFO_AW:0]     count;
  logic                              do_push;
  logic                              do_pop;

  assign do_push     = push_i && !full_o;
  assign do_pop      = pop_i && !empty_o;
  assign empty_o     = (count == '0);
  assign not_empty_o = !empty_o;
  assign full_o      = (count == qdr_mem_pkg::FIFO_FULL);
  assign cmd_o       = mem[rd_ptr];

  // depth is a power of two so the pointers wrap by themselves
  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge qdr_clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= cmd_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/qdr_burst_seq.sv */
`default_nettype none
`timescale 1ns/1ps

module qdr_burst_seq (
  input  wire                                    qdr_clk_i,
  input  wire                                    wb_rst_i,
  input  wire qdr_mem_pkg::qdr_cmd_t             cmd_i,
  input  wire                                    not_empty_i,
  input  wire                                    qdr_phy_rdy_i,
  input  wire                                    qdr_wr_full_i,
  input  wire                                    qdr_rd_full_i,
  input  wire [qdr_mem_pkg::BEAT_BITS-1:0]       qdr_rd_data_i,
  input  wire                                    qdr_rd_valid_i,
  output logic                                   pop_o,
  output logic                                   idle_o,
  output qdr_mem_pkg::rd_result_t                rd_res_o,
  output logic                                   qdr_rst_o,
  output logic [qdr_mem_pkg::ADDR_BITS-1:0]      qdr_wr_addr_o,
  output logic [qdr_mem_pkg::BEAT_BITS-1:0]      qdr_wr_data_o,
  output logic [qdr_mem_pkg::BEAT_MASK-1:0]      qdr_wr_be_o,
  output logic                                   qdr_wr_addr_en_o,
  output logic                                   qdr_wr_data_en_o,
  output logic [qdr_mem_pkg::ADDR_BITS-1:0]      qdr_rd_addr_o,
  output logic                                   qdr_rd_en_o
);

  typedef enum logic [1:0] {SEQ_IDLE, SEQ_WR1, SEQ_RD_WAIT} seq_state_e;

  seq_state_e                              state;
  logic [qdr_mem_pkg::RST_CNT_W-1:0]       rst_cnt;
  logic                                    ready;
  logic                                    start_wr;
  logic                                    start_rd;
  logic                                    rd_beat;
  logic                                    rd_valid_q;
  qdr_mem_pkg::burst_u                     rd_data_q;
  logic [qdr_mem_pkg::BEAT_BITS-1:0]       wr_hi_data;
  logic [qdr_mem_pkg::BEAT_MASK-1:0]       wr_hi_be;

  // controller reset stays up a few cycles past ours
  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      rst_cnt <= qdr_mem_pkg::RST_LOAD;
    end else if (rst_cnt != '0) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  assign qdr_rst_o = (rst_cnt != '0);
  assign ready     = !qdr_rst_o && qdr_phy_rdy_i;
  assign start_wr  = (state == SEQ_IDLE) && ready && not_empty_i && !cmd_i.is_read
                     && !qdr_wr_full_i;
  assign start_rd  = (state == SEQ_IDLE) && ready && not_empty_i && cmd_i.is_read
                     && !qdr_rd_full_i;
  assign pop_o     = start_wr || start_rd;
  // also covers a queued command and the result still on its way out
  assign idle_o    = (state == SEQ_IDLE) && !not_empty_i && !rd_valid_q;

  assign rd_res_o.valid = rd_valid_q;
  assign rd_res_o.data  = rd_data_q;

  always_ff @(posedge qdr_clk_i) begin
    if (wb_rst_i) begin
      state            <= SEQ_IDLE;
      qdr_wr_addr_en_o <= 1'b0;
      qdr_wr_data_en_o <= 1'b0;
      qdr_rd_en_o      <= 1'b0;
      rd_valid_q       <= 1'b0;
      rd_beat          <= 1'b0;
    end else begin
      qdr_wr_addr_en_o <= start_wr;
      qdr_wr_data_en_o <= start_wr || (state == SEQ_WR1);
      qdr_rd_en_o      <= start_rd;
      rd_valid_q       <= 1'b0;
      case (state)
        SEQ_IDLE: begin
          if (start_wr) begin
            state <= SEQ_WR1;
          end else if (start_rd) begin
            state   <= SEQ_RD_WAIT;
            rd_beat <= 1'b0;
          end
        end
        SEQ_WR1: begin
          state <= SEQ_IDLE;
        end
        SEQ_RD_WAIT: begin
          if (qdr_rd_valid_i) begin
            rd_beat <= 1'b1;
            if (rd_beat) begin
              rd_valid_q <= 1'b1;
              state      <= SEQ_IDLE;
            end
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge qdr_clk_i) begin
    if (start_wr) begin
      qdr_wr_addr_o <= cmd_i.addr;
      qdr_wr_data_o <= cmd_i.data.beat[0];
      qdr_wr_be_o   <= cmd_i.mask[qdr_mem_pkg::BEAT_MASK-1:0];
      wr_hi_data    <= cmd_i.data.beat[1];
      wr_hi_be      <= cmd_i.mask[qdr_mem_pkg::MASK_BITS-1:qdr_mem_pkg::BEAT_MASK];
    end else if (state == SEQ_WR1) begin
      qdr_wr_data_o <= wr_hi_data;
      qdr_wr_be_o   <= wr_hi_be;
    end
    if (start_rd) begin
      qdr_rd_addr_o <= cmd_i.addr;
    end
    // beat 0 lands in the low half
    if ((state == SEQ_RD_WAIT) && qdr_rd_valid_i) begin
      rd_data_q.beat[rd_beat] <= qdr_rd_data_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/qdr_cpu_interface.sv */
`default_nettype none
`timescale 1ns/1ps

module qdr_cpu_interface (
  input  wire                                qdr_clk_i,
  input  wire                                wb_rst_i,
  input  wire qdr_bus_pkg::bus_req_t         bus_i,
  output logic [qdr_bus_pkg::BUS_DW-1:0]     dat_o,
  output logic                               ack_o,
  output logic                               qdr_rst_o,
  input  wire                                qdr_phy_rdy_i,
  input  wire                                qdr_wr_full_i,
  input  wire                                qdr_rd_full_i,
  output logic [qdr_mem_pkg::ADDR_BITS-1:0]  qdr_wr_addr_o,
  output logic [qdr_mem_pkg::BEAT_BITS-1:0]  qdr_wr_data_o,
  output logic [qdr_mem_pkg::BEAT_MASK-1:0]  qdr_wr_be_o,
  output logic                               qdr_wr_addr_en_o,
  output logic                               qdr_wr_data_en_o,
  output logic [qdr_mem_pkg::ADDR_BITS-1:0]  qdr_rd_addr_o,
  input  wire [qdr_mem_pkg::BEAT_BITS-1:0]   qdr_rd_data_i,
  input  wire                                qdr_rd_valid_i,
  output logic                               qdr_rd_en_o
);

  qdr_mem_pkg::qdr_cmd_t    reg_cmd;
  qdr_mem_pkg::qdr_cmd_t    head_cmd;
  qdr_mem_pkg::rd_result_t  rd_res;
  logic                     push;
  logic                     pop;
  logic                     fifo_full;
  logic                     fifo_not_empty;
  logic                     seq_idle;

  qdr_cmd_regs regs0 (
    .qdr_clk_i  (qdr_clk_i),
    .wb_rst_i   (wb_rst_i),
    .bus_i      (bus_i),
    .full_i     (fifo_full),
    .rd_res_i   (rd_res),
    .seq_idle_i (seq_idle),
    .dat_o      (dat_o),
    .ack_o      (ack_o),
    .push_o     (push),
    .cmd_o      (reg_cmd)
  );

  qdr_cmd_fifo fifo0 (
    .qdr_clk_i   (qdr_clk_i),
    .wb_rst_i    (wb_rst_i),
    .push_i      (push),
    .cmd_i       (reg_cmd),
    .pop_i       (pop),
    .cmd_o       (head_cmd),
    .not_empty_o (fifo_not_empty),
    .full_o      (fifo_full),
    .empty_o     ()
  );

  qdr_burst_seq seq0 (
    .qdr_clk_i        (qdr_clk_i),
    .wb_rst_i         (wb_rst_i),
    .cmd_i            (head_cmd),
    .not_empty_i      (fifo_not_empty),
    .qdr_phy_rdy_i    (qdr_phy_rdy_i),
    .qdr_wr_full_i    (qdr_wr_full_i),
    .qdr_rd_full_i    (qdr_rd_full_i),
    .qdr_rd_data_i    (qdr_rd_data_i),
    .qdr_rd_valid_i   (qdr_rd_valid_i),
    .pop_o            (pop),
    .idle_o           (seq_idle),
    .rd_res_o         (rd_res),
    .qdr_rst_o        (qdr_rst_o),
    .qdr_wr_addr_o    (qdr_wr_addr_o),
    .qdr_wr_data_o    (qdr_wr_data_o),
    .qdr_wr_be_o      (qdr_wr_be_o),
    .qdr_wr_addr_en_o (qdr_wr_addr_en_o),
    .qdr_wr_data_en_o (qdr_wr_data_en_o),
    .qdr_rd_addr_o    (qdr_rd_addr_o),
    .qdr_rd_en_o      (qdr_rd_en_o)
  );

endmodule

`default_nettype wire

/* sim/qdr_sram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_sram_model (
  input  wire                                  qdr_clk_i,
  input  wire                                  wb_rst_i,
  input  wire                                  chaos_i,
  input  wire [7:0]                            noise_i,
  input  wire [qdr_mem_pkg::ADDR_BITS-1:0]     wr_addr_i,
  input  wire [qdr_mem_pkg::BEAT_BITS-1:0]     wr_data_i,
  input  wire [qdr_mem_pkg::BEAT_MASK-1:0]     wr_be_i,
  input  wire                                  wr_addr_en_i,
  input  wire                                  wr_data_en_i,
  input  wire [qdr_mem_pkg::ADDR_BITS-1:0]     rd_addr_i,
  input  wire                                  rd_en_i,
  output logic                                 wr_full_o,
  output logic                                 rd_full_o,
  output logic [qdr_mem_pkg::BEAT_BITS-1:0]    rd_data_o,
  output logic                                 rd_valid_o
);

  logic [71:0]                          mem [logic [qdr_mem_pkg::ADDR_BITS-1:0]];
  logic [qdr_mem_pkg::ADDR_BITS-1:0]    wr_addr_q;
  logic [qdr_mem_pkg::ADDR_BITS-1:0]    rd_addr_q;
  logic                                 rd_pend;
  logic                                 rd_beat;
  logic [2:0]                           wait_cnt;

  // untouched locations hold a pattern built from the whole address
  function automatic logic [71:0] fetch(input logic [21:0] a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return {a, ~a, a ^ 22'h2aaaaa, 6'h15};
  endfunction

  // one enable bit per 9-bit byte of the beat
  task automatic store(input logic [21:0] a, input logic hi, input logic [35:0] d,
                       input logic [3:0] be);
    logic [71:0] w;
    w = fetch(a);
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        w[int'(hi) * 36 + i * 9 +: 9] = d[i * 9 +: 9];
      end
    end
    mem[a] = w;
  endtask

  assign wr_full_o = chaos_i && (noise_i[1:0] == 2'b00);
  assign rd_full_o = chaos_i && (noise_i[3:2] == 2'b00);

  always @(posedge qdr_clk_i) begin
    if (wr_addr_en_i) begin
      wr_addr_q <= wr_addr_i;
      store(wr_addr_i, 1'b0, wr_data_i, wr_be_i);
    end else if (wr_data_en_i) begin
      store(wr_addr_q, 1'b1, wr_data_i, wr_be_i);
    end
  end

  always @(posedge qdr_clk_i) begin
    logic [71:0] w;
    w = fetch(rd_addr_q);
    if (wb_rst_i) begin
      rd_pend    <= 1'b0;
      rd_beat    <= 1'b0;
      rd_valid_o <= 1'b0;
      rd_data_o  <= '0;
      wait_cnt   <= '0;
    end else begin
      rd_valid_o <= 1'b0;
      if (rd_en_i) begin
        rd_pend   <= 1'b1;
        rd_addr_q <= rd_addr_i;
        rd_beat   <= 1'b0;
        wait_cnt  <= chaos_i ? noise_i[6:4] : 3'd0;
      end else if (rd_pend) begin
        if (wait_cnt != 3'd0) begin
          wait_cnt <= wait_cnt - 3'd1;
        end else begin
          rd_valid_o <= 1'b1;
          rd_data_o  <= rd_beat ? w[71:36] : w[35:0];
          rd_beat    <= 1'b1;
          rd_pend    <= !rd_beat;
          // sometimes a gap between the two beats
          wait_cnt   <= chaos_i ? {2'b00, noise_i[7]} : 3'd0;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim/qdr_cpu_interface_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_cpu_interface_properties (
  input wire qdr_clk_i,
  input wire wb_rst_i,
  input wire qdr_rst_i,
  input wire pop_i,
  input wire not_empty_i,
  input wire wr_addr_en_i,
  input wire wr_data_en_i,
  input wire rd_en_i
);

  int fail_cnt = 0;

  wr_beat1_follows: assert property (@(posedge qdr_clk_i) disable iff (wb_rst_i)
    wr_addr_en_i |=> wr_data_en_i && !wr_addr_en_i)
    else begin
      fail_cnt++;
      $error("write beat 1 did not follow beat 0");
    end

  quiet_in_reset: assert property (@(posedge qdr_clk_i) disable iff (wb_rst_i)
    qdr_rst_i |-> !(wr_addr_en_i || wr_data_en_i || rd_en_i))
    else begin
      fail_cnt++;
      $error("QDR enable active while the controller is in reset");
    end

  no_pop_when_empty: assert property (@(posedge qdr_clk_i) disable iff (wb_rst_i)
    pop_i |-> not_empty_i)
    else begin
      fail_cnt++;
      $error("pop from an empty command FIFO");
    end

endmodule

bind qdr_burst_seq qdr_cpu_interface_properties props0 (
  .qdr_clk_i    (qdr_clk_i),
  .wb_rst_i     (wb_rst_i),
  .qdr_rst_i    (qdr_rst_o),
  .pop_i        (pop_o),
  .not_empty_i  (not_empty_i),
  .wr_addr_en_i (qdr_wr_addr_en_o),
  .wr_data_en_i (qdr_wr_data_en_o),
  .rd_en_i      (qdr_rd_en_o)
);

`default_nettype wire

/* sim/tb_qdr_cpu_interface.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_qdr_cpu_interface;

  localparam logic [31:0] SEED = 32'd55264;
  localparam int BUS_TIMEOUT = 200;
  localparam int POLL_LIMIT  = 400;
  localparam int OPS         = 200;

  logic                           clk;
  logic                           rst;
  qdr_bus_pkg::bus_req_t          bus;
  logic [15:0]                    dat;
  logic                           ack;
  logic                           qdr_rst;
  logic                           phy_rdy;
  logic                           wr_full;
  logic                           rd_full;
  logic [21:0]                    wr_addr;
  logic [35:0]                    wr_data;
  logic [3:0]                     wr_be;
  logic                           wr_addr_en;
  logic                           wr_data_en;
  logic [21:0]                    rd_addr;
  logic [35:0]                    rd_data;
  logic                           rd_valid;
  logic                           rd_en;
  logic                           chaos;
  logic [7:0]                     noise;
  logic [31:0]                    stim_st;
  logic [31:0]                    noise_st;
  logic [71:0]                    model_mem [logic [21:0]];

  qdr_cpu_interface dut0 (
    .qdr_clk_i        (clk),
    .wb_rst_i         (rst),
    .bus_i            (bus),
    .dat_o            (dat),
    .ack_o            (ack),
    .qdr_rst_o        (qdr_rst),
    .qdr_phy_rdy_i    (phy_rdy),
    .qdr_wr_full_i    (wr_full),
    .qdr_rd_full_i    (rd_full),
    .qdr_wr_addr_o    (wr_addr),
    .qdr_wr_data_o    (wr_data),
    .qdr_wr_be_o      (wr_be),
    .qdr_wr_addr_en_o (wr_addr_en),
    .qdr_wr_data_en_o (wr_data_en),
    .qdr_rd_addr_o    (rd_addr),
    .qdr_rd_data_i    (rd_data),
    .qdr_rd_valid_i   (rd_valid),
    .qdr_rd_en_o      (rd_en)
  );

  qdr_sram_model sram0 (
    .qdr_clk_i    (clk),
    .wb_rst_i     (rst),
    .chaos_i      (chaos),
    .noise_i      (noise),
    .wr_addr_i    (wr_addr),
    .wr_data_i    (wr_data),
    .wr_be_i      (wr_be),
    .wr_addr_en_i (wr_addr_en),
    .wr_data_en_i (wr_data_en),
    .rd_addr_i    (rd_addr),
    .rd_en_i      (rd_en),
    .wr_full_o    (wr_full),
    .rd_full_o    (rd_full),
    .rd_data_o    (rd_data),
    .rd_valid_o   (rd_valid)
  );

  always #2 clk = ~clk;

  function automatic logic [15:0] lcg_step(inout logic [31:0] st);
    st = st * 32'd1103515245 + 32'd12345;
    return st[30:15];
  endfunction

  function automatic logic [15:0] rand16();
    return lcg_step(stim_st);
  endfunction

  // full flags and read latency in the SRAM model
  always @(negedge clk) begin
    noise <= 8'(lcg_step(noise_st));
  end

  function automatic logic [71:0] model_get(input logic [21:0] a);
    if (model_mem.exists(a)) begin
      return model_mem[a];
    end
    return {a, ~a, a ^ 22'h2aaaaa, 6'h15};
  endfunction

  // mask bit b enables 9-bit byte b
  task automatic model_write(input logic [21:0] a, input logic [7:0] m, input logic [71:0] d);
    logic [71:0] w;
    w = model_get(a);
    for (int b = 0; b < 8; b++) begin
      if (m[b]) begin
        w[b * 9 +: 9] = d[b * 9 +: 9];
      end
    end
    model_mem[a] = w;
  endtask

  task automatic abort_run(input string why);
    $display("ERROR %s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [79:0] got, input logic [79:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // starts on a falling edge and returns on the falling edge that sees ack
  task automatic bus_access(input logic we, input logic [6:0] idx, input logic [15:0] wdat,
                            output logic [15:0] rdat);
    int n;
    bus.cyc = 1'b1;
    bus.stb = 1'b1;
    bus.we  = we;
    bus.sel = 2'b11;
    bus.adr = {idx, 1'b0};
    bus.dat = wdat;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > BUS_TIMEOUT) begin
        abort_run("bus cycle got no ack");
      end
    end while (!ack);
    rdat = dat;
    bus  = '0;
  endtask

  task automatic reg_write(input logic [6:0] idx, input logic [15:0] v);
    logic [15:0] unused;
    bus_access(1'b1, idx, v, unused);
  endtask

  task automatic reg_read(input logic [6:0] idx, output logic [15:0] v);
    bus_access(1'b0, idx, 16'h0000, v);
  endtask

  task automatic wait_status(input logic [15:0] exp, input logic [15:0] msk);
    logic [15:0] s;
    int          n;
    n = 0;
    reg_read(qdr_bus_pkg::REG_STATUS, s);
    while ((s & msk) != exp) begin
      n++;
      if (n > POLL_LIMIT) begin
        abort_run("STATUS never reached the expected value");
      end
      reg_read(qdr_bus_pkg::REG_STATUS, s);
    end
  endtask

  task automatic stage_write(input logic [21:0] a, input logic [7:0] m, input logic [71:0] d);
    logic [79:0] wide;
    wide = 80'(d);
    reg_write(qdr_bus_pkg::REG_ADDR_LO, a[15:0]);
    reg_write(qdr_bus_pkg::REG_ADDR_HI, 16'(a[21:16]));
    reg_write(qdr_bus_pkg::REG_MASK, 16'(m));
    for (int k = 0; k < 5; k++) begin
      reg_write(7'(qdr_bus_pkg::REG_WDATA0 + k), wide[k * 16 +: 16]);
    end
  endtask

  task automatic issue_write(input logic [21:0] a, input logic [7:0] m, input logic [71:0] d);
    stage_write(a, m, d);
    reg_write(qdr_bus_pkg::REG_CTRL, 16'h0001);
    model_write(a, m, d);
  endtask

  task automatic issue_read(input logic [21:0] a);
    logic [79:0] got;
    logic [15:0] w;
    reg_write(qdr_bus_pkg::REG_ADDR_LO, a[15:0]);
    reg_write(qdr_bus_pkg::REG_ADDR_HI, 16'(a[21:16]));
    reg_write(qdr_bus_pkg::REG_CTRL, 16'h0002);
    // rd_done set and nothing left in flight
    wait_status(16'h0001, 16'h0003);
    for (int k = 0; k < 5; k++) begin
      reg_read(7'(qdr_bus_pkg::REG_RDATA0 + k), w);
      got[k * 16 +: 16] = w;
    end
    check("RDATA", got, 80'(model_get(a)));
  endtask

  function automatic logic [71:0] random_burst();
    return 72'({rand16(), rand16(), rand16(), rand16(), rand16()});
  endfunction

  function automatic logic [21:0] pick_addr(input logic [3:0] k);
    return {k, 14'(int'(k) * 997), k};
  endfunction

  task automatic random_ops(input int n);
    logic [15:0] r;
    for (int i = 0; i < n; i++) begin
      r = rand16();
      if (r[0]) begin
        issue_write(pick_addr(r[12:9]), 8'(rand16()), random_burst());
      end else begin
        issue_read(pick_addr(r[12:9]));
      end
    end
  endtask

  initial begin
    logic [15:0] v;
    logic [15:0] got;
    logic [21:0] a;
    logic [71:0] d;
    int          n;
    clk      = 1'b0;
    rst      = 1'b1;
    bus      = '0;
    phy_rdy  = 1'b0;
    chaos    = 1'b0;
    noise    = '0;
    stim_st  = SEED;
    noise_st = SEED;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check("ack_o", 80'(ack), 80'(0));
    check("qdr enables", 80'({wr_addr_en, wr_data_en, rd_en}), 80'(0));
    check("qdr_rst_o", 80'(qdr_rst), 80'(1));
    rst = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (qdr_rst && n < 4 * qdr_mem_pkg::RST_STRETCH);
    check("qdr_rst_o cycles", 80'(n), 80'(qdr_mem_pkg::RST_STRETCH));

    // a queued write must wait for the PHY
    issue_write(pick_addr(4'd3), 8'hff, random_burst());
    repeat (16) begin
      @(negedge clk);
      check("qdr enables", 80'({wr_addr_en, wr_data_en, rd_en}), 80'(0));
    end
    // busy while the write sits in the queue
    reg_read(qdr_bus_pkg::REG_STATUS, got);
    check("STATUS", 80'(got), 80'(16'h0002));
    phy_rdy = 1'b1;
    wait_status(16'h0000, 16'h0003);

    // readback is truncated to the 22-bit address, 8-bit mask and 72-bit burst
    v = rand16();
    reg_write(qdr_bus_pkg::REG_ADDR_LO, v);
    reg_read(qdr_bus_pkg::REG_ADDR_LO, got);
    check("ADDR_LO", 80'(got), 80'(v));
    v = rand16();
    reg_write(qdr_bus_pkg::REG_ADDR_HI, v);
    reg_read(qdr_bus_pkg::REG_ADDR_HI, got);
    check("ADDR_HI", 80'(got), 80'(v & 16'h003f));
    v = rand16();
    reg_write(qdr_bus_pkg::REG_MASK, v);
    reg_read(qdr_bus_pkg::REG_MASK, got);
    check("MASK", 80'(got), 80'(v & 16'h00ff));
    for (int k = 0; k < 5; k++) begin
      v = rand16();
      reg_write(7'(qdr_bus_pkg::REG_WDATA0 + k), v);
      reg_read(7'(qdr_bus_pkg::REG_WDATA0 + k), got);
      check("WDATA", 80'(got), 80'((k == 4) ? (v & 16'h00ff) : v));
    end
    reg_read(qdr_bus_pkg::REG_STATUS, got);
    check("STATUS", 80'(got), 80'(0));

    a = pick_addr(4'd7);
    issue_write(a, 8'hff, random_burst());
    issue_read(a);
    issue_write(a, 8'h5a, random_burst());
    issue_read(a);

    random_ops(OPS);
    chaos = 1'b1;
    random_ops(OPS);

    // with the PHY down the FIFO fills and the fifth CTRL write stalls
    wait_status(16'h0000, 16'h0002);
    phy_rdy = 1'b0;
    for (int i = 0; i < 4; i++) begin
      issue_write(pick_addr(4'(i)), 8'(rand16()), random_burst());
    end
    a = pick_addr(4'd4);
    v = rand16();
    d = random_burst();
    stage_write(a, 8'(v), d);
    fork
      begin
        reg_write(qdr_bus_pkg::REG_CTRL, 16'h0001);
        if (!phy_rdy) begin
          abort_run("CTRL write was acked while the command FIFO was full");
        end
      end
      begin
        repeat (12) @(negedge clk);
        phy_rdy = 1'b1;
      end
    join
    model_write(a, 8'(v), d);
    for (int i = 0; i < 5; i++) begin
      issue_read(pick_addr(4'(i)));
    end

    if (dut0.seq0.props0.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
rtl/qdr_bus_pkg.sv
rtl/qdr_mem_pkg.sv
rtl/qdr_cmd_regs.sv
rtl/qdr_cmd_fifo.sv
rtl/qdr_burst_seq.sv
rtl/qdr_cpu_interface.sv
sim/qdr_sram_model.sv
sim/qdr_cpu_interface_properties.sv
sim/tb_qdr_cpu_interface.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       := tb_qdr_cpu_interface
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
